// ==== common/platform_pkg.sv ====
// all addresses are word addresses and bit 15 selects the peripheral space
package platform_pkg;

    // host and framebuffer bus widths
    localparam int BUS_AW = 16;
    localparam int BUS_DW = 32;

    // set for peripherals, clear for the framebuffer
    localparam int PERIPH_SEL_BIT = 15;

    // peripheral word addresses
    localparam logic [BUS_AW-1:0] LED_ADDR        = 16'h8000;
    localparam logic [BUS_AW-1:0] MTIME_ADDR      = 16'h8010;
    localparam logic [BUS_AW-1:0] MTIMECMP_ADDR   = 16'h8011;
    // video registers occupy a window of four words from here
    localparam logic [BUS_AW-1:0] VIDEO_BASE_ADDR = 16'h8020;

    // framebuffer depth in words, as log2
    localparam int FB_DEPTH_LOG2_DEFAULT = 10;

endpackage

// ==== common/video_pkg.sv ====
// register offsets are relative to the video window and only two bits wide
package video_pkg;

    // first framebuffer word to fetch
    localparam logic [1:0] VID_REG_BASE  = 2'd0;
    // number of words to fetch
    localparam logic [1:0] VID_REG_COUNT = 2'd1;
    // write bit 0 to start, read bit 0 for busy
    localparam logic [1:0] VID_REG_CTRL  = 2'd2;

    typedef enum logic [1:0] {
        // waiting for a start
        FETCH_IDLE,
        // read held on the framebuffer bus
        FETCH_REQ,
        // returned word presented as a pixel
        FETCH_EMIT
    } fetch_state_e;

endpackage

// ==== source/periph_bus.sv ====
// peripheral cycles always ack one cycle after stb and unmapped addresses read as zero
`timescale 1ns/1ps

module periph_bus (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // host port
    input  logic                              host_cyc_i,
    input  logic                              host_stb_i,
    input  logic                              host_we_i,
    input  logic [platform_pkg::BUS_AW-1:0]   host_adr_i,
    input  logic [platform_pkg::BUS_DW-1:0]   host_dat_i,
    output logic [platform_pkg::BUS_DW-1:0]   host_dat_o,
    output logic                              host_ack_o,

    // framebuffer master toward the arbiter
    output logic                              hfb_cyc_o,
    output logic                              hfb_stb_o,
    output logic                              hfb_we_o,
    output logic [platform_pkg::BUS_AW-1:0]   hfb_adr_o,
    output logic [platform_pkg::BUS_DW-1:0]   hfb_wdat_o,
    input  logic [platform_pkg::BUS_DW-1:0]   hfb_rdat_i,
    input  logic                              hfb_ack_i,

    // timer slave
    output logic                              tim_stb_o,
    output logic                              tim_we_o,
    output logic [platform_pkg::BUS_AW-1:0]   tim_adr_o,
    output logic [platform_pkg::BUS_DW-1:0]   tim_wdat_o,
    input  logic [platform_pkg::BUS_DW-1:0]   tim_rdat_i,

    // video register slave
    output logic                              vcfg_stb_o,
    output logic                              vcfg_we_o,
    output logic [1:0]                        vcfg_adr_o,
    output logic [platform_pkg::BUS_DW-1:0]   vcfg_wdat_o,
    input  logic [platform_pkg::BUS_DW-1:0]   vcfg_rdat_i,

    output logic [7:0]                        leds_o
);

    logic                            is_periph;
    logic                            periph_new;
    logic                            led_sel;
    logic                            tim_sel;
    logic                            vcfg_sel;
    logic                            periph_ack_q;
    logic [platform_pkg::BUS_DW-1:0] periph_rdat;
    logic [platform_pkg::BUS_DW-1:0] periph_rdat_q;
    logic [platform_pkg::BUS_DW-1:0] led_q;

    assign is_periph = host_adr_i[platform_pkg::PERIPH_SEL_BIT];
    // first cycle of a peripheral access only, so a held stb acts once
    assign periph_new = host_cyc_i & host_stb_i & is_periph & ~periph_ack_q;

    assign led_sel  = host_adr_i == platform_pkg::LED_ADDR;
    assign tim_sel  = (host_adr_i == platform_pkg::MTIME_ADDR) ||
                      (host_adr_i == platform_pkg::MTIMECMP_ADDR);
    assign vcfg_sel = host_adr_i[platform_pkg::BUS_AW-1:2] ==
                      platform_pkg::VIDEO_BASE_ADDR[platform_pkg::BUS_AW-1:2];

    // framebuffer path passes through untouched
    assign hfb_cyc_o  = host_cyc_i & ~is_periph;
    assign hfb_stb_o  = host_stb_i & ~is_periph;
    assign hfb_we_o   = host_we_i;
    assign hfb_adr_o  = host_adr_i;
    assign hfb_wdat_o = host_dat_i;

    assign tim_stb_o  = periph_new & tim_sel;
    assign tim_we_o   = host_we_i;
    assign tim_adr_o  = host_adr_i;
    assign tim_wdat_o = host_dat_i;

    assign vcfg_stb_o  = periph_new & vcfg_sel;
    assign vcfg_we_o   = host_we_i;
    assign vcfg_adr_o  = host_adr_i[1:0];
    assign vcfg_wdat_o = host_dat_i;

    always_comb begin
        periph_rdat = '0;
        if (led_sel)
            periph_rdat = led_q;
        else if (tim_sel)
            periph_rdat = tim_rdat_i;
        else if (vcfg_sel)
            periph_rdat = vcfg_rdat_i;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            periph_ack_q <= 1'b0;
            led_q        <= '0;
        end else begin
            periph_ack_q <= periph_new;
            if (periph_new && led_sel && host_we_i)
                led_q <= host_dat_i;
        end
    end

    // read data sampled with the request, presented with the ack
    always_ff @(posedge clk_i) begin
        if (periph_new)
            periph_rdat_q <= periph_rdat;
    end

    assign host_ack_o = periph_ack_q | hfb_ack_i;
    assign host_dat_o = is_periph ? periph_rdat_q : hfb_rdat_i;
    assign leds_o     = led_q[7:0];

endmodule

// ==== source/sec_arbiter.sv ====
// masters must hold stb until ack and drop it the cycle after, or a held strobe starts a new transfer
`timescale 1ns/1ps

module sec_arbiter (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // host master
    input  logic                              hfb_cyc_i,
    input  logic                              hfb_stb_i,
    input  logic                              hfb_we_i,
    input  logic [platform_pkg::BUS_AW-1:0]   hfb_adr_i,
    input  logic [platform_pkg::BUS_DW-1:0]   hfb_wdat_i,
    output logic [platform_pkg::BUS_DW-1:0]   hfb_rdat_o,
    output logic                              hfb_ack_o,

    // video fetch master, read only
    input  logic                              vfb_cyc_i,
    input  logic                              vfb_stb_i,
    input  logic [platform_pkg::BUS_AW-1:0]   vfb_adr_i,
    output logic [platform_pkg::BUS_DW-1:0]   vfb_rdat_o,
    output logic                              vfb_ack_o,

    // framebuffer memory
    output logic                              mem_stb_o,
    output logic                              mem_we_o,
    output logic [platform_pkg::BUS_AW-1:0]   mem_adr_o,
    output logic [platform_pkg::BUS_DW-1:0]   mem_wdat_o,
    input  logic [platform_pkg::BUS_DW-1:0]   mem_rdat_i,
    input  logic                              mem_ack_i
);

    logic host_req;
    logic vid_req;
    logic sel_vid;
    logic locked_q;
    logic grant_vid_q;
    logic prio_vid_q;

    assign host_req = hfb_cyc_i & hfb_stb_i;
    assign vid_req  = vfb_cyc_i & vfb_stb_i;

    // locked grant wins, otherwise the priority bit breaks a tie
    assign sel_vid = locked_q ? grant_vid_q : (vid_req & (prio_vid_q | ~host_req));

    assign mem_stb_o  = sel_vid ? vid_req : host_req;
    assign mem_we_o   = ~sel_vid & hfb_we_i;
    assign mem_adr_o  = sel_vid ? vfb_adr_i : hfb_adr_i;
    assign mem_wdat_o = hfb_wdat_i;

    assign hfb_ack_o  = mem_ack_i & ~sel_vid;
    assign vfb_ack_o  = mem_ack_i & sel_vid;
    assign hfb_rdat_o = sel_vid ? '0 : mem_rdat_i;
    assign vfb_rdat_o = sel_vid ? mem_rdat_i : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            locked_q    <= 1'b0;
            grant_vid_q <= 1'b0;
            prio_vid_q  <= 1'b0;
        end else if (mem_ack_i) begin
            locked_q   <= 1'b0;
            // the other master goes first next time
            prio_vid_q <= ~sel_vid;
        end else if (mem_stb_o) begin
            locked_q    <= 1'b1;
            grant_vid_q <= sel_vid;
        end
    end

endmodule

// ==== source/fb_ram.sv ====
// only the low FB_DEPTH_LOG2 address bits index the memory, so higher words alias
`timescale 1ns/1ps

module fb_ram #(
    parameter int FB_DEPTH_LOG2 = 10
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              mem_stb_i,
    input  logic                              mem_we_i,
    input  logic [platform_pkg::BUS_AW-1:0]   mem_adr_i,
    input  logic [platform_pkg::BUS_DW-1:0]   mem_wdat_i,
    output logic [platform_pkg::BUS_DW-1:0]   mem_rdat_o,
    output logic                              mem_ack_o
);

    logic [platform_pkg::BUS_DW-1:0] mem [2**FB_DEPTH_LOG2];
    logic                            access;

    // stb seen in the acked cycle belongs to the finished transfer
    assign access = mem_stb_i & ~mem_ack_o;

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (mem_we_i)
                mem[mem_adr_i[FB_DEPTH_LOG2-1:0]] <= mem_wdat_i;
            mem_rdat_o <= mem[mem_adr_i[FB_DEPTH_LOG2-1:0]];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i)
            mem_ack_o <= 1'b0;
        else
            mem_ack_o <= access;
    end

endmodule

// ==== source/mtimer.sv ====
// mtime is 32 bits only and wraps, and the interrupt is a plain level with no clear
`timescale 1ns/1ps

module mtimer (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              tim_stb_i,
    input  logic                              tim_we_i,
    input  logic [platform_pkg::BUS_AW-1:0]   tim_adr_i,
    input  logic [platform_pkg::BUS_DW-1:0]   tim_wdat_i,
    output logic [platform_pkg::BUS_DW-1:0]   tim_rdat_o,
    output logic                              timer_irq_o
);

    logic [platform_pkg::BUS_DW-1:0] mtime_q;
    logic [platform_pkg::BUS_DW-1:0] mtimecmp_q;
    logic                            wr_mtime;
    logic                            wr_cmp;

    assign wr_mtime = tim_stb_i & tim_we_i & (tim_adr_i == platform_pkg::MTIME_ADDR);
    assign wr_cmp   = tim_stb_i & tim_we_i & (tim_adr_i == platform_pkg::MTIMECMP_ADDR);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q    <= '0;
            // all ones keeps the interrupt quiet until software arms it
            mtimecmp_q <= '1;
        end else begin
            if (wr_mtime)
                mtime_q <= tim_wdat_i;
            else
                mtime_q <= mtime_q + 1'b1;
            if (wr_cmp)
                mtimecmp_q <= tim_wdat_i;
        end
    end

    assign tim_rdat_o  = (tim_adr_i == platform_pkg::MTIMECMP_ADDR) ? mtimecmp_q : mtime_q;
    assign timer_irq_o = mtime_q >= mtimecmp_q;

endmodule

// ==== video/video_fetch.sv ====
// pixels come out in the system clock domain and a start while busy is dropped
`timescale 1ns/1ps

module video_fetch #(
    parameter int FB_DEPTH_LOG2 = 10
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // configuration registers
    input  logic                              vcfg_stb_i,
    input  logic                              vcfg_we_i,
    input  logic [1:0]                        vcfg_adr_i,
    input  logic [platform_pkg::BUS_DW-1:0]   vcfg_wdat_i,
    output logic [platform_pkg::BUS_DW-1:0]   vcfg_rdat_o,

    // framebuffer read master
    output logic                              vfb_cyc_o,
    output logic                              vfb_stb_o,
    output logic [platform_pkg::BUS_AW-1:0]   vfb_adr_o,
    input  logic [platform_pkg::BUS_DW-1:0]   vfb_rdat_i,
    input  logic                              vfb_ack_i,

    output logic [platform_pkg::BUS_DW-1:0]   pixel_o,
    output logic                              pixel_valid_o
);

    video_pkg::fetch_state_e          state_q;
    logic [FB_DEPTH_LOG2-1:0]         base_q;
    logic [platform_pkg::BUS_AW-1:0]  count_q;
    logic [FB_DEPTH_LOG2-1:0]         addr_q;
    logic [platform_pkg::BUS_AW-1:0]  remain_q;
    logic [platform_pkg::BUS_DW-1:0]  pixel_q;
    logic                             busy;
    logic                             cfg_wr;
    logic                             start;

    assign busy   = state_q != video_pkg::FETCH_IDLE;
    assign cfg_wr = vcfg_stb_i & vcfg_we_i;
    assign start  = cfg_wr & (vcfg_adr_i == video_pkg::VID_REG_CTRL) & vcfg_wdat_i[0];

    // base and count are free to change while a fetch runs on its own copies
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            base_q  <= '0;
            count_q <= '0;
        end else if (cfg_wr) begin
            if (vcfg_adr_i == video_pkg::VID_REG_BASE)
                base_q <= vcfg_wdat_i[FB_DEPTH_LOG2-1:0];
            if (vcfg_adr_i == video_pkg::VID_REG_COUNT)
                count_q <= vcfg_wdat_i[platform_pkg::BUS_AW-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= video_pkg::FETCH_IDLE;
            addr_q   <= '0;
            remain_q <= '0;
        end else begin
            case (state_q)
                video_pkg::FETCH_IDLE: begin
                    // a zero count never leaves idle
                    if (start && count_q != '0) begin
                        addr_q   <= base_q;
                        remain_q <= count_q;
                        state_q  <= video_pkg::FETCH_REQ;
                    end
                end
                video_pkg::FETCH_REQ: begin
                    if (vfb_ack_i) begin
                        // address wraps at the framebuffer depth by width alone
                        addr_q   <= addr_q + 1'b1;
                        remain_q <= remain_q - 1'b1;
                        state_q  <= video_pkg::FETCH_EMIT;
                    end
                end
                video_pkg::FETCH_EMIT: begin
                    if (remain_q == '0)
                        state_q <= video_pkg::FETCH_IDLE;
                    else
                        state_q <= video_pkg::FETCH_REQ;
                end
                default: state_q <= video_pkg::FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == video_pkg::FETCH_REQ && vfb_ack_i)
            pixel_q <= vfb_rdat_i;
    end

    assign vfb_cyc_o     = state_q == video_pkg::FETCH_REQ;
    assign vfb_stb_o     = state_q == video_pkg::FETCH_REQ;
    assign vfb_adr_o     = {{(platform_pkg::BUS_AW-FB_DEPTH_LOG2){1'b0}}, addr_q};
    assign pixel_o       = pixel_q;
    assign pixel_valid_o = state_q == video_pkg::FETCH_EMIT;

    always_comb begin
        vcfg_rdat_o = '0;
        case (vcfg_adr_i)
            video_pkg::VID_REG_BASE:  vcfg_rdat_o[FB_DEPTH_LOG2-1:0] = base_q;
            video_pkg::VID_REG_COUNT: vcfg_rdat_o[platform_pkg::BUS_AW-1:0] = count_q;
            video_pkg::VID_REG_CTRL:  vcfg_rdat_o[0] = busy;
            default:                  vcfg_rdat_o = '0;
        endcase
    end

endmodule

// ==== source/yarc_mini_platform.sv ====
// single clock domain and the host port follows classic single transfers with no stall
`timescale 1ns/1ps

module yarc_mini_platform #(
    parameter int FB_DEPTH_LOG2 = platform_pkg::FB_DEPTH_LOG2_DEFAULT
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    // host port
    input  logic                              host_cyc_i,
    input  logic                              host_stb_i,
    input  logic                              host_we_i,
    input  logic [platform_pkg::BUS_AW-1:0]   host_adr_i,
    input  logic [platform_pkg::BUS_DW-1:0]   host_dat_i,
    output logic [platform_pkg::BUS_DW-1:0]   host_dat_o,
    output logic                              host_ack_o,

    output logic [7:0]                        leds_o,
    output logic                              timer_irq_o,
    output logic [platform_pkg::BUS_DW-1:0]   pixel_o,
    output logic                              pixel_valid_o
);

    // host to framebuffer
    logic                            hfb_cyc;
    logic                            hfb_stb;
    logic                            hfb_we;
    logic [platform_pkg::BUS_AW-1:0] hfb_adr;
    logic [platform_pkg::BUS_DW-1:0] hfb_wdat;
    logic [platform_pkg::BUS_DW-1:0] hfb_rdat;
    logic                            hfb_ack;

    // timer registers
    logic                            tim_stb;
    logic                            tim_we;
    logic [platform_pkg::BUS_AW-1:0] tim_adr;
    logic [platform_pkg::BUS_DW-1:0] tim_wdat;
    logic [platform_pkg::BUS_DW-1:0] tim_rdat;

    // video registers
    logic                            vcfg_stb;
    logic                            vcfg_we;
    logic [1:0]                      vcfg_adr;
    logic [platform_pkg::BUS_DW-1:0] vcfg_wdat;
    logic [platform_pkg::BUS_DW-1:0] vcfg_rdat;

    // video fetch to framebuffer
    logic                            vfb_cyc;
    logic                            vfb_stb;
    logic [platform_pkg::BUS_AW-1:0] vfb_adr;
    logic [platform_pkg::BUS_DW-1:0] vfb_rdat;
    logic                            vfb_ack;

    // arbiter to memory
    logic                            mem_stb;
    logic                            mem_we;
    logic [platform_pkg::BUS_AW-1:0] mem_adr;
    logic [platform_pkg::BUS_DW-1:0] mem_wdat;
    logic [platform_pkg::BUS_DW-1:0] mem_rdat;
    logic                            mem_ack;

    periph_bus periph_bus_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .host_cyc_i  (host_cyc_i),
        .host_stb_i  (host_stb_i),
        .host_we_i   (host_we_i),
        .host_adr_i  (host_adr_i),
        .host_dat_i  (host_dat_i),
        .host_dat_o  (host_dat_o),
        .host_ack_o  (host_ack_o),
        .hfb_cyc_o   (hfb_cyc),
        .hfb_stb_o   (hfb_stb),
        .hfb_we_o    (hfb_we),
        .hfb_adr_o   (hfb_adr),
        .hfb_wdat_o  (hfb_wdat),
        .hfb_rdat_i  (hfb_rdat),
        .hfb_ack_i   (hfb_ack),
        .tim_stb_o   (tim_stb),
        .tim_we_o    (tim_we),
        .tim_adr_o   (tim_adr),
        .tim_wdat_o  (tim_wdat),
        .tim_rdat_i  (tim_rdat),
        .vcfg_stb_o  (vcfg_stb),
        .vcfg_we_o   (vcfg_we),
        .vcfg_adr_o  (vcfg_adr),
        .vcfg_wdat_o (vcfg_wdat),
        .vcfg_rdat_i (vcfg_rdat),
        .leds_o      (leds_o)
    );

    sec_arbiter sec_arbiter_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .hfb_cyc_i  (hfb_cyc),
        .hfb_stb_i  (hfb_stb),
        .hfb_we_i   (hfb_we),
        .hfb_adr_i  (hfb_adr),
        .hfb_wdat_i (hfb_wdat),
        .hfb_rdat_o (hfb_rdat),
        .hfb_ack_o  (hfb_ack),
        .vfb_cyc_i  (vfb_cyc),
        .vfb_stb_i  (vfb_stb),
        .vfb_adr_i  (vfb_adr),
        .vfb_rdat_o (vfb_rdat),
        .vfb_ack_o  (vfb_ack),
        .mem_stb_o  (mem_stb),
        .mem_we_o   (mem_we),
        .mem_adr_o  (mem_adr),
        .mem_wdat_o (mem_wdat),
        .mem_rdat_i (mem_rdat),
        .mem_ack_i  (mem_ack)
    );

    fb_ram #(.FB_DEPTH_LOG2(FB_DEPTH_LOG2)) fb_ram_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .mem_stb_i  (mem_stb),
        .mem_we_i   (mem_we),
        .mem_adr_i  (mem_adr),
        .mem_wdat_i (mem_wdat),
        .mem_rdat_o (mem_rdat),
        .mem_ack_o  (mem_ack)
    );

    mtimer mtimer_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .tim_stb_i   (tim_stb),
        .tim_we_i    (tim_we),
        .tim_adr_i   (tim_adr),
        .tim_wdat_i  (tim_wdat),
        .tim_rdat_o  (tim_rdat),
        .timer_irq_o (timer_irq_o)
    );

    video_fetch #(.FB_DEPTH_LOG2(FB_DEPTH_LOG2)) video_fetch_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .vcfg_stb_i    (vcfg_stb),
        .vcfg_we_i     (vcfg_we),
        .vcfg_adr_i    (vcfg_adr),
        .vcfg_wdat_i   (vcfg_wdat),
        .vcfg_rdat_o   (vcfg_rdat),
        .vfb_cyc_o     (vfb_cyc),
        .vfb_stb_o     (vfb_stb),
        .vfb_adr_o     (vfb_adr),
        .vfb_rdat_i    (vfb_rdat),
        .vfb_ack_i     (vfb_ack),
        .pixel_o       (pixel_o),
        .pixel_valid_o (pixel_valid_o)
    );

endmodule

// ==== dv/fb_bus_checker.sv ====
// checks sample on the rising clock and are off while reset is held
`timescale 1ns/1ps

module fb_bus_checker (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic mem_stb_i,
    input  logic mem_ack_i,
    input  logic hfb_ack_i,
    input  logic vfb_ack_i,
    input  logic host_req_i,
    input  logic vid_req_i,
    input  logic sel_vid_i
);

    // the memory acks only a strobe it saw on the previous edge
    ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_ack_i |-> $past(mem_stb_i))
        else $error("memory ack without a preceding strobe");

    // ack goes to one master only, and that master still holds its request
    single_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (hfb_ack_i || vfb_ack_i) |->
            (hfb_ack_i ? (host_req_i && !vfb_ack_i) : vid_req_i))
        else $error("ack sent to both masters or to a master without a request");

    // pending transfer keeps its master until the ack
    grant_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (mem_stb_i && !mem_ack_i) |=> (sel_vid_i == $past(sel_vid_i)))
        else $error("grant changed while a transfer was pending");

endmodule

bind sec_arbiter fb_bus_checker fb_bus_checker_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_stb_i  (mem_stb_o),
    .mem_ack_i  (mem_ack_i),
    .hfb_ack_i  (hfb_ack_o),
    .vfb_ack_i  (vfb_ack_o),
    .host_req_i (host_req),
    .vid_req_i  (vid_req),
    .sel_vid_i  (sel_vid)
);

// ==== dv/yarc_mini_platform_tb.sv ====
// uses the default framebuffer depth and keeps every host access inside the first FB_WORDS
`timescale 1ns/1ps

module yarc_mini_platform_tb;

    localparam int FB_WORDS = 2**platform_pkg::FB_DEPTH_LOG2_DEFAULT;
    // tests need about 3000 cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam logic [15:0] VID_BASE  = platform_pkg::VIDEO_BASE_ADDR + 16'(video_pkg::VID_REG_BASE);
    localparam logic [15:0] VID_COUNT = platform_pkg::VIDEO_BASE_ADDR + 16'(video_pkg::VID_REG_COUNT);
    localparam logic [15:0] VID_CTRL  = platform_pkg::VIDEO_BASE_ADDR + 16'(video_pkg::VID_REG_CTRL);

    logic        clk;
    logic        rst_n;
    logic        host_cyc;
    logic        host_stb;
    logic        host_we;
    logic [15:0] host_adr;
    logic [31:0] host_wdat;
    logic [31:0] host_rdat;
    logic        host_ack;
    logic [7:0]  leds;
    logic        timer_irq;
    logic [31:0] pixel;
    logic        pixel_valid;

    logic [31:0] fb_model [FB_WORDS];
    logic [31:0] pixels [$];
    logic [31:0] rng_state;
    int          cycle_cnt = 0;

    yarc_mini_platform #(
        .FB_DEPTH_LOG2(platform_pkg::FB_DEPTH_LOG2_DEFAULT)
    ) yarc_mini_platform_i (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .host_cyc_i    (host_cyc),
        .host_stb_i    (host_stb),
        .host_we_i     (host_we),
        .host_adr_i    (host_adr),
        .host_dat_i    (host_wdat),
        .host_dat_o    (host_rdat),
        .host_ack_o    (host_ack),
        .leds_o        (leds),
        .timer_irq_o   (timer_irq),
        .pixel_o       (pixel),
        .pixel_valid_o (pixel_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // pixels sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && pixel_valid)
            pixels.push_back(pixel);
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic bus_transfer(input logic we, input logic [15:0] adr,
                                input logic [31:0] wdat, output logic [31:0] rdat);
        host_cyc  = 1'b1;
        host_stb  = 1'b1;
        host_we   = we;
        host_adr  = adr;
        host_wdat = wdat;
        @(negedge clk);
        while (!host_ack)
            @(negedge clk);
        rdat = host_rdat;
        @(posedge clk);
        #1;
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] adr, input logic [31:0] data);
        logic [31:0] unused_rd;
        bus_transfer(1'b1, adr, data, unused_rd);
    endtask

    task automatic bus_read(input logic [15:0] adr, output logic [31:0] data);
        bus_transfer(1'b0, adr, '0, data);
    endtask

    task automatic fb_write(input logic [15:0] adr, input logic [31:0] data);
        bus_write(adr, data);
        fb_model[adr] = data;
    endtask

    task automatic start_fetch(input int base, input int count);
        bus_write(VID_BASE, base);
        bus_write(VID_COUNT, count);
        bus_write(VID_CTRL, 32'h1);
    endtask

    task automatic wait_fetch_done();
        logic [31:0] ctrl;
        ctrl = 32'h1;
        while (ctrl[0])
            bus_read(VID_CTRL, ctrl);
    endtask

    task automatic check_pixels(input int base, input int count);
        int i;
        check_value("pixel count", pixels.size(), count);
        for (i = 0; i < count; i++)
            check_value("pixel_o", pixels[i], fb_model[(base + i) % FB_WORDS]);
    endtask

    task automatic reset_and_leds();
        logic [31:0] rd;
        check_value("leds_o", leds, '0);
        check_value("timer_irq_o", timer_irq, '0);
        check_value("pixel_valid_o", pixel_valid, '0);
        check_value("host_ack_o", host_ack, '0);
        bus_write(platform_pkg::LED_ADDR, 32'h5a3c_96c3);
        bus_read(platform_pkg::LED_ADDR, rd);
        check_value("led register", rd, 32'h5a3c_96c3);
        check_value("leds_o", leds, 32'hc3);
        // unmapped peripheral word
        bus_read(16'h8100, rd);
        check_value("unmapped read", rd, '0);
    endtask

    task automatic fb_readback();
        logic [15:0] adrs [64];
        logic [31:0] rd;
        int          i;
        for (i = 0; i < 64; i++) begin
            adrs[i] = 16'(next_rand() % FB_WORDS);
            fb_write(adrs[i], next_rand());
        end
        for (i = 0; i < 64; i++) begin
            bus_read(adrs[i], rd);
            check_value("host_dat_o", rd, fb_model[adrs[i]]);
        end
    endtask

    task automatic timer_interrupt();
        logic [31:0] t;
        logic [31:0] rd;
        bus_read(platform_pkg::MTIME_ADDR, t);
        bus_write(platform_pkg::MTIMECMP_ADDR, t + 200);
        check_value("timer_irq_o", timer_irq, '0);
        bus_read(platform_pkg::MTIMECMP_ADDR, rd);
        check_value("mtimecmp", rd, t + 200);
        repeat (300) @(posedge clk);
        #1;
        check_value("timer_irq_o", timer_irq, 32'h1);
        bus_write(platform_pkg::MTIMECMP_ADDR, '1);
        check_value("timer_irq_o", timer_irq, '0);
    endtask

    task automatic pixel_stream();
        int base;
        int i;
        // runs past the top word to check the wrap
        base = FB_WORDS - 6;
        for (i = 0; i < 16; i++)
            fb_write(16'((base + i) % FB_WORDS), next_rand());
        pixels.delete();
        start_fetch(base, 16);
        wait_fetch_done();
        check_pixels(base, 16);
    endtask

    task automatic contention();
        logic [15:0] adr;
        logic [31:0] rd;
        int          i;
        for (i = 0; i < 32; i++)
            fb_write(16'(256 + i), next_rand());
        pixels.delete();
        start_fetch(256, 32);
        // host traffic in a region the fetch never touches
        for (i = 0; i < 24; i++) begin
            adr = 16'(512 + i);
            fb_write(adr, next_rand());
            bus_read(adr, rd);
            check_value("host_dat_o", rd, fb_model[adr]);
        end
        wait_fetch_done();
        check_pixels(256, 32);
    endtask

    task automatic fetch_edge_cases();
        logic [31:0] rd;
        pixels.delete();
        start_fetch(100, 0);
        bus_read(VID_CTRL, rd);
        check_value("fetch busy", rd[0], '0);
        repeat (10) @(posedge clk);
        #1;
        check_value("pixel count", pixels.size(), '0);
        start_fetch(256, 16);
        bus_read(VID_CTRL, rd);
        check_value("fetch busy", rd[0], 32'h1);
        // new base and a second start while the first fetch runs
        bus_write(VID_BASE, 600);
        bus_write(VID_CTRL, 32'h1);
        wait_fetch_done();
        repeat (10) @(posedge clk);
        #1;
        check_pixels(256, 16);
    endtask

    initial begin
        rst_n     = 1'b0;
        host_cyc  = 1'b0;
        host_stb  = 1'b0;
        host_we   = 1'b0;
        host_adr  = '0;
        host_wdat = '0;
        rng_state = 32'd60;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        reset_and_leds();
        fb_readback();
        timer_interrupt();
        pixel_stream();
        contention();
        fetch_edge_cases();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
common/platform_pkg.sv
common/video_pkg.sv
source/periph_bus.sv
source/sec_arbiter.sv
source/fb_ram.sv
source/mtimer.sv
video/video_fetch.sv
source/yarc_mini_platform.sv
dv/fb_bus_checker.sv
dv/yarc_mini_platform_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module yarc_mini_platform_tb -o yarc_mini_platform_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/yarc_mini_platform_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
